//--- compile.f
+incdir+.
bpu_isa_pkg.sv
bpu_cfg_pkg.sv
bpu_update_if.sv
pred_table.sv
inst_decode.sv
tage_predictor.sv
btb.sv
next_pc_select.sv
bpu_top.sv
tb_bpu.sv

//--- tb_bpu_model.svh
`ifndef TB_BPU_MODEL_SVH
`define TB_BPU_MODEL_SVH

// shadow copy of every predictor table
ctr_t        m_bm      [512];
logic [9:0]  m_t0_tag  [256];
ctr_t        m_t0_ctr  [256];
logic [9:0]  m_t1_tag  [256];
ctr_t        m_t1_ctr  [256];
logic        m_btb_vld [256];
logic [21:0] m_btb_tag [256];
addr_t       m_btb_tgt [256];
hist_t       m_hist;
logic [31:0] lfsr_state = 32'd1;

// galois lfsr stepped once per bit handed out
function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r[i] = lfsr_state[0];
        lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
    return r;
endfunction

task automatic init_shadow();
    m_hist = '0;
    for (int i = 0; i < 512; i++) begin
        m_bm[i] = 2'd1;
    end
    for (int i = 0; i < 256; i++) begin
        m_t0_tag[i]  = '0;
        m_t0_ctr[i]  = 2'd1;
        m_t1_tag[i]  = '0;
        m_t1_ctr[i]  = 2'd1;
        m_btb_vld[i] = 1'b0;
        m_btb_tag[i] = '0;
        m_btb_tgt[i] = '0;
    end
endtask

function automatic addr_t b_offset(inst_t w);
    return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
endfunction

function automatic addr_t j_offset(inst_t w);
    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
endfunction

function automatic logic [7:0] t0_slot(addr_t pc, hist_t h);
    return pc[7:0] ^ h[7:0];
endfunction

function automatic logic [7:0] t1_slot(addr_t pc, hist_t h);
    return pc[7:0] ^ h[15:8];
endfunction

function automatic logic [9:0] t0_key(addr_t pc, hist_t h);
    return pc[17:8] ^ h[15:6];
endfunction

function automatic logic [9:0] t1_key(addr_t pc, hist_t h);
    return pc[17:8] ^ {2'b00, h[7:0]};
endfunction

// 2 = T1, 1 = T0, 0 = bimodal
function automatic int provider_of(addr_t pc, hist_t h);
    if (m_t1_tag[t1_slot(pc, h)][9:4] == t1_key(pc, h)[9:4]) begin
        return 2;
    end
    if (m_t0_tag[t0_slot(pc, h)][9:4] == t0_key(pc, h)[9:4]) begin
        return 1;
    end
    return 0;
endfunction

function automatic ctr_t bump(ctr_t c, logic taken);
    if (taken) begin
        return (c == 2'd3) ? c : c + 2'd1;
    end
    return (c == 2'd0) ? c : c - 2'd1;
endfunction

task automatic expected_prediction(input addr_t pc, input inst_t w, output logic cti,
                                   output logic tkn, output addr_t npc);
    logic [6:0] opc;
    logic [7:0] bt;
    logic       hit;
    logic       dir;
    opc = w[6:0];
    bt  = pc[9:2];
    hit = m_btb_vld[bt] && (m_btb_tag[bt] == pc[31:10]);
    case (provider_of(pc, m_hist))
        2:       dir = m_t1_ctr[t1_slot(pc, m_hist)][1];
        1:       dir = m_t0_ctr[t0_slot(pc, m_hist)][1];
        default: dir = m_bm[pc[9:1]][1];
    endcase
    cti = (opc == OPC_BRANCH) || (opc == OPC_JAL) || (opc == OPC_JALR);
    tkn = 1'b0;
    npc = pc + 32'd4;
    if (opc == OPC_JAL) begin
        tkn = 1'b1;
        npc = hit ? m_btb_tgt[bt] : pc + j_offset(w);
    end else if (opc == OPC_JALR && hit) begin
        tkn = 1'b1;
        npc = m_btb_tgt[bt];
    end else if (opc == OPC_BRANCH && dir) begin
        tkn = 1'b1;
        npc = hit ? m_btb_tgt[bt] : pc + b_offset(w);
    end
endtask

task automatic update_shadow(addr_t pc, hist_t h, logic taken, logic correct, addr_t target);
    logic [7:0] i0;
    logic [7:0] i1;
    logic [9:0] g0;
    logic [9:0] g1;
    int         prov;
    i0   = t0_slot(pc, h);
    i1   = t1_slot(pc, h);
    g0   = t0_key(pc, h);
    g1   = t1_key(pc, h);
    prov = provider_of(pc, h);  // before any table changes
    m_bm[pc[9:1]] = bump(m_bm[pc[9:1]], taken);
    if (prov == 2) begin
        m_t1_ctr[i1] = correct ? bump(m_t1_ctr[i1], taken) : (taken ? 2'd3 : 2'd0);
    end else if (prov == 1) begin
        m_t0_ctr[i0] = correct ? bump(m_t0_ctr[i0], taken) : (taken ? 2'd3 : 2'd0);
    end else if (!correct) begin
        if (m_t1_tag[i1] != g1) begin
            m_t1_tag[i1] = g1;
            m_t1_ctr[i1] = taken ? 2'd2 : 2'd1;
        end else if (m_t0_tag[i0] != g0) begin
            m_t0_tag[i0] = g0;
            m_t0_ctr[i0] = taken ? 2'd2 : 2'd1;
        end
    end
    if (taken) begin
        m_btb_vld[pc[9:2]] = 1'b1;
        m_btb_tag[pc[9:2]] = pc[31:10];
        m_btb_tgt[pc[9:2]] = target;
    end
    m_hist = {m_hist[14:0], taken};
endtask

`endif

//--- tb_bpu.sv
`timescale 1ns/1ps

module tb_bpu import bpu_isa_pkg::*, bpu_cfg_pkg::*; ();

    localparam int CLK_PERIOD   = 4;
    localparam int N_RESET      = 24;
    localparam int N_TRAIN      = 24;
    localparam int N_BTB        = 3;
    localparam int N_HIST       = 32;
    localparam int N_RAND       = 400;
    localparam int TOTAL_CYCLES = N_RESET + N_TRAIN + 1 + 2 * N_BTB + 19 + N_HIST + N_RAND + 8;
    localparam int WATCHDOG_NS  = TOTAL_CYCLES * CLK_PERIOD + 400;

    logic  clk = 1'b0;
    logic  rst = 1'b1;
    addr_t if_pc = '0;
    inst_t if_inst = '0;
    logic  ex_valid = 1'b0;
    logic  ex_taken = 1'b0;
    logic  ex_pdt_true = 1'b0;
    addr_t ex_pc = '0;
    hist_t ex_hist = '0;
    addr_t ex_target = '0;
    logic  is_cti_o;
    addr_t pred_pc_o;
    logic  pred_taken_o;
    hist_t history_o;

    int    checks = 0;
    int    errors = 0;
    int    test_checks;
    int    test_errors;
    string test_name;

    `include "tb_bpu_model.svh"

    always #(CLK_PERIOD / 2) clk = ~clk;

    bpu_top DUT (
        .clk               (clk),
        .rst               (rst),
        .if_pc_i           (if_pc),
        .if_inst_i         (if_inst),
        .ex_branch_valid_i (ex_valid),
        .ex_branch_taken_i (ex_taken),
        .ex_pdt_true_i     (ex_pdt_true),
        .ex_pc_i           (ex_pc),
        .ex_history_i      (ex_hist),
        .ex_target_i       (ex_target),
        .is_cti_o          (is_cti_o),
        .pred_pc_o         (pred_pc_o),
        .pred_taken_o      (pred_taken_o),
        .history_o         (history_o)
    );

    task automatic compare(string what, logic [31:0] exp, logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic begin_test(string name);
        test_name   = name;
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic end_test();
        $display("%s: %0d checks, %0d errors", test_name, checks - test_checks,
                 errors - test_errors);
    endtask

    task automatic reset_dut();
        @(negedge clk);
        rst      = 1'b1;
        ex_valid = 1'b0;
        init_shadow();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    endtask

    function automatic inst_t make_inst(logic [6:0] opc);
        logic [31:0] r;
        r = rand_bits(25);
        return {r[24:0], opc};
    endfunction

    // kind 0 is an ALU op and the rest are transfers
    function automatic inst_t random_inst(logic [1:0] kind);
        case (kind)
            2'd1:    return make_inst(OPC_BRANCH);
            2'd2:    return make_inst(OPC_JAL);
            2'd3:    return make_inst(OPC_JALR);
            default: return make_inst(7'b0010011);
        endcase
    endfunction

    function automatic addr_t rand_addr();
        return rand_bits(30) << 2;
    endfunction

    // fetch and optionally resolve the same instruction in one cycle
    task automatic drive_cycle(addr_t pc, inst_t w, logic resolve, logic taken, addr_t target);
        logic  e_cti;
        logic  e_tkn;
        addr_t e_npc;
        @(negedge clk);
        expected_prediction(pc, w, e_cti, e_tkn, e_npc);
        if_pc       = pc;
        if_inst     = w;
        ex_valid    = resolve;
        ex_taken    = taken;
        ex_pdt_true = (e_tkn == taken);
        ex_pc       = pc;
        ex_hist     = history_o;  // history the lookup is using
        ex_target   = target;
        #1;                       // just ahead of the rising edge
        compare("is_cti", e_cti, is_cti_o);
        compare("pred_taken", e_tkn, pred_taken_o);
        compare("pred_pc", e_npc, pred_pc_o);
        compare("history", m_hist, history_o);
        if (resolve) begin
            update_shadow(pc, m_hist, taken, e_tkn == taken, target);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests completed");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        addr_t       pc;
        addr_t       tgt;
        inst_t       w;
        logic [31:0] r;
        logic [1:0]  kind;

        reset_dut();

        begin_test("after_reset");
        repeat (N_RESET) begin
            pc = rand_addr();
            drive_cycle(pc, random_inst(rand_bits(2)), 1'b0, 1'b0, '0);
        end
        end_test();

        begin_test("bimodal_training");
        pc = rand_addr();
        w  = make_inst(OPC_BRANCH);
        repeat (N_TRAIN) begin
            drive_cycle(pc, w, 1'b1, 1'b1, pc + b_offset(w));
        end
        // bit 10 only moves the btb tag so the trained counters still provide
        pc = pc ^ 32'h0000_0400;
        drive_cycle(pc, w, 1'b0, 1'b0, '0);
        compare("trained taken", 1, pred_taken_o);
        compare("trained target", pc + b_offset(w), pred_pc_o);
        end_test();

        begin_test("btb_fill");
        repeat (N_BTB) begin
            pc  = rand_addr();
            tgt = rand_addr();
            drive_cycle(pc, make_inst(OPC_JAL), 1'b1, 1'b1, tgt);
            drive_cycle(pc, make_inst(OPC_JALR), 1'b0, 1'b0, '0);
            compare("jalr taken", 1, pred_taken_o);
            compare("jalr target", tgt, pred_pc_o);
        end
        end_test();

        begin_test("tagged_alloc");
        reset_dut();
        // nonzero tag bits keep reset entries from matching and bit 17 is left for the alias pc
        pc = (rand_addr() & 32'hFFFD_FFFF) | 32'h0001_0000;
        w  = make_inst(OPC_BRANCH);
        drive_cycle(pc, w, 1'b1, 1'b1, pc + b_offset(w));  // bimodal miss
        repeat (16) begin
            drive_cycle(pc | 32'h0002_0000, make_inst(7'b0010011), 1'b1, 1'b0, '0);
        end
        drive_cycle(pc, w, 1'b1, 1'b0, '0);  // history back to zero
        compare("allocated taken", 1, pred_taken_o);
        drive_cycle(pc, w, 1'b0, 1'b0, '0);
        compare("flipped taken", 0, pred_taken_o);
        end_test();

        begin_test("history");
        repeat (N_HIST) begin
            r   = rand_bits(2);
            pc  = rand_addr();
            w   = make_inst(OPC_BRANCH);
            tgt = rand_addr();
            drive_cycle(pc, w, r[0], r[1], tgt);
        end
        end_test();

        begin_test("random_mix");
        repeat (N_RAND) begin
            pc   = rand_bits(12) << 2;  // small space so entries alias
            kind = rand_bits(2);
            w    = random_inst(kind);
            r    = rand_bits(2);
            tgt  = rand_addr();
            drive_cycle(pc, w, (kind != 2'd0) && r[0], (kind == 2'd1) ? r[1] : 1'b1, tgt);
        end
        end_test();

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- bpu_top.sv
`timescale 1ns/1ps

module bpu_top import bpu_isa_pkg::*, bpu_cfg_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  addr_t if_pc_i,
    input  inst_t if_inst_i,
    input  logic  ex_branch_valid_i,
    input  logic  ex_branch_taken_i,
    input  logic  ex_pdt_true_i,
    input  addr_t ex_pc_i,
    input  hist_t ex_history_i,
    input  addr_t ex_target_i,
    output logic  is_cti_o,
    output addr_t pred_pc_o,
    output logic  pred_taken_o,
    output hist_t history_o
);

    logic  is_branch;
    logic  is_jal;
    logic  is_jalr;
    addr_t jal_target;
    addr_t branch_target;
    logic  dir_taken;
    logic  btb_hit;
    addr_t btb_target;

    bpu_update_if upd ();

    // execute-stage resolution drives the source side
    assign upd.valid        = ex_branch_valid_i;
    assign upd.taken        = ex_branch_taken_i;
    assign upd.pred_correct = ex_pdt_true_i;
    assign upd.pc           = ex_pc_i;
    assign upd.history      = ex_history_i;
    assign upd.target       = ex_target_i;

    inst_decode u_decode (
        .if_pc_i         (if_pc_i),
        .if_inst_i       (if_inst_i),
        .is_branch_o     (is_branch),
        .is_jal_o        (is_jal),
        .is_jalr_o       (is_jalr),
        .jal_target_o    (jal_target),
        .branch_target_o (branch_target)
    );

    tage_predictor u_tage (
        .clk         (clk),
        .rst         (rst),
        .if_pc_i     (if_pc_i),
        .upd         (upd),
        .dir_taken_o (dir_taken),
        .history_o   (history_o)
    );

    btb #(
        .BTB_IDX_W (BTB_IDX_W)
    ) u_btb (
        .clk      (clk),
        .rst      (rst),
        .if_pc_i  (if_pc_i),
        .upd      (upd),
        .hit_o    (btb_hit),
        .target_o (btb_target)
    );

    next_pc_select u_sel (
        .if_pc_i         (if_pc_i),
        .is_branch_i     (is_branch),
        .is_jal_i        (is_jal),
        .is_jalr_i       (is_jalr),
        .jal_target_i    (jal_target),
        .branch_target_i (branch_target),
        .dir_taken_i     (dir_taken),
        .btb_hit_i       (btb_hit),
        .btb_target_i    (btb_target),
        .is_cti_o        (is_cti_o),
        .pred_pc_o       (pred_pc_o),
        .pred_taken_o    (pred_taken_o)
    );

endmodule

//--- next_pc_select.sv
`timescale 1ns/1ps

module next_pc_select import bpu_isa_pkg::*; (
    input  addr_t if_pc_i,
    input  logic  is_branch_i,
    input  logic  is_jal_i,
    input  logic  is_jalr_i,
    input  addr_t jal_target_i,
    input  addr_t branch_target_i,
    input  logic  dir_taken_i,
    input  logic  btb_hit_i,
    input  addr_t btb_target_i,
    output logic  is_cti_o,
    output addr_t pred_pc_o,
    output logic  pred_taken_o
);

    addr_t seq_pc;

    assign seq_pc = if_pc_i + addr_t'(4);

    always_comb begin
        is_cti_o     = is_branch_i || is_jal_i || is_jalr_i;
        pred_taken_o = 1'b0;
        pred_pc_o    = seq_pc;  // fall through by default
        if (is_jal_i) begin
            pred_taken_o = 1'b1;
            pred_pc_o    = btb_hit_i ? btb_target_i : jal_target_i;
        end else if (is_jalr_i) begin
            // register target, only the btb can supply it
            pred_taken_o = btb_hit_i;
            pred_pc_o    = btb_hit_i ? btb_target_i : seq_pc;
        end else if (is_branch_i && dir_taken_i) begin
            pred_taken_o = 1'b1;
            pred_pc_o    = btb_hit_i ? btb_target_i : branch_target_i;
        end
    end

endmodule

//--- btb.sv
`timescale 1ns/1ps

module btb import bpu_isa_pkg::*, bpu_cfg_pkg::*; #(
    parameter int BTB_IDX_W = 8
) (
    input  logic       clk,
    input  logic       rst,
    input  addr_t      if_pc_i,
    bpu_update_if.sink upd,
    output logic       hit_o,
    output addr_t      target_o
);

    logic [BTB_IDX_W-1:0] rd_idx;
    logic [BTB_IDX_W-1:0] wr_idx;
    btb_entry_t           rd_ent;
    btb_entry_t           wr_ent;

    assign rd_idx = if_pc_i[BTB_IDX_W+1:2];  // word aligned index
    assign wr_idx = upd.pc[BTB_IDX_W+1:2];

    assign hit_o    = rd_ent.valid && (rd_ent.tag == if_pc_i[XLEN-1 -: BTB_TAG_W]);
    assign target_o = rd_ent.target;

    // only taken transfers are worth a slot
    assign wr_ent = '{valid: 1'b1, tag: upd.pc[XLEN-1 -: BTB_TAG_W], target: upd.target};

    pred_table #(
        .DEPTH     (2**BTB_IDX_W),
        .entry_t   (btb_entry_t),
        .RESET_VAL (BTB_ENTRY_RST)
    ) u_tbl (
        .clk         (clk),
        .rst         (rst),
        .rd_idx_a_i  (rd_idx),
        .rd_idx_b_i  (wr_idx),
        .wr_en_i     (upd.valid && upd.taken),
        .wr_idx_i    (wr_idx),
        .wr_data_i   (wr_ent),
        .rd_data_a_o (rd_ent),
        .rd_data_b_o ()            // no update-time read needed
    );

endmodule

//--- tage_predictor.sv
`timescale 1ns/1ps

module tage_predictor import bpu_isa_pkg::*, bpu_cfg_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  addr_t      if_pc_i,
    bpu_update_if.sink upd,
    output logic       dir_taken_o,
    output hist_t      history_o
);

    hist_t ghist;

    logic [BM_IDX_W-1:0]  bm_idx_f;
    logic [TAG_IDX_W-1:0] t0_idx_f;
    logic [TAG_IDX_W-1:0] t1_idx_f;
    ctr_t                 bm_ctr_f;
    tag_entry_t           t0_ent_f;
    tag_entry_t           t1_ent_f;
    provider_e            prov_f;

    logic [BM_IDX_W-1:0]  bm_idx_u;
    logic [TAG_IDX_W-1:0] t0_idx_u;
    logic [TAG_IDX_W-1:0] t1_idx_u;
    tag_t                 t0_tag_u;
    tag_t                 t1_tag_u;
    ctr_t                 bm_ctr_u;
    tag_entry_t           t0_ent_u;
    tag_entry_t           t1_ent_u;
    provider_e            prov_u;

    ctr_t                 bm_wdata;
    logic                 t0_we;
    logic                 t1_we;
    tag_entry_t           t0_wdata;
    tag_entry_t           t1_wdata;

    // longest matching history wins
    function automatic provider_e pick(tag_entry_t e0, tag_t tag0,
                                       tag_entry_t e1, tag_t tag1);
        if (part_match(e1.tag, tag1)) begin
            return T1;
        end
        if (part_match(e0.tag, tag0)) begin
            return T0;
        end
        return BIMODAL;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist <= '0;
        end else if (upd.valid) begin
            ghist <= {ghist[HIST_W-2:0], upd.taken};  // newest outcome in lsb
        end
    end

    assign history_o = ghist;

    assign bm_idx_f = bm_index(if_pc_i);
    assign t0_idx_f = t0_index(if_pc_i, ghist);
    assign t1_idx_f = t1_index(if_pc_i, ghist);
    assign prov_f   = pick(t0_ent_f, t0_tag(if_pc_i, ghist), t1_ent_f, t1_tag(if_pc_i, ghist));

    always_comb begin
        case (prov_f)
            T1:      dir_taken_o = t1_ent_f.ctr[1];
            T0:      dir_taken_o = t0_ent_f.ctr[1];
            default: dir_taken_o = bm_ctr_f[1];
        endcase
    end

    // provider recomputed from the resolved pc and its history
    assign bm_idx_u = bm_index(upd.pc);
    assign t0_idx_u = t0_index(upd.pc, upd.history);
    assign t1_idx_u = t1_index(upd.pc, upd.history);
    assign t0_tag_u = t0_tag(upd.pc, upd.history);
    assign t1_tag_u = t1_tag(upd.pc, upd.history);
    assign prov_u   = pick(t0_ent_u, t0_tag_u, t1_ent_u, t1_tag_u);

    assign bm_wdata = ctr_step(bm_ctr_u, upd.taken);  // bimodal trains on every update

    always_comb begin
        t0_we    = 1'b0;
        t1_we    = 1'b0;
        t0_wdata = t0_ent_u;
        t1_wdata = t1_ent_u;
        if (upd.valid && prov_u == T1) begin
            t1_we        = 1'b1;
            t1_wdata.ctr = upd.pred_correct ? ctr_step(t1_ent_u.ctr, upd.taken)
                                            : (upd.taken ? CTR_STRONG_T : CTR_STRONG_NT);
        end else if (upd.valid && prov_u == T0) begin
            t0_we        = 1'b1;
            t0_wdata.ctr = upd.pred_correct ? ctr_step(t0_ent_u.ctr, upd.taken)
                                            : (upd.taken ? CTR_STRONG_T : CTR_STRONG_NT);
        end else if (upd.valid && !upd.pred_correct) begin
            // bimodal missed, allocate in T1 first
            if (t1_ent_u.tag != t1_tag_u) begin
                t1_we    = 1'b1;
                t1_wdata = '{tag: t1_tag_u, ctr: upd.taken ? CTR_WEAK_T : CTR_WEAK_NT};
            end else if (t0_ent_u.tag != t0_tag_u) begin
                t0_we    = 1'b1;
                t0_wdata = '{tag: t0_tag_u, ctr: upd.taken ? CTR_WEAK_T : CTR_WEAK_NT};
            end
        end
    end

    pred_table #(
        .DEPTH     (2**BM_IDX_W),
        .entry_t   (ctr_t),
        .RESET_VAL (CTR_WEAK_NT)
    ) u_bimodal (
        .clk         (clk),
        .rst         (rst),
        .rd_idx_a_i  (bm_idx_f),
        .rd_idx_b_i  (bm_idx_u),
        .wr_en_i     (upd.valid),
        .wr_idx_i    (bm_idx_u),
        .wr_data_i   (bm_wdata),
        .rd_data_a_o (bm_ctr_f),
        .rd_data_b_o (bm_ctr_u)
    );

    pred_table #(
        .DEPTH     (2**TAG_IDX_W),
        .entry_t   (tag_entry_t),
        .RESET_VAL (TAG_ENTRY_RST)
    ) u_t0 (
        .clk         (clk),
        .rst         (rst),
        .rd_idx_a_i  (t0_idx_f),
        .rd_idx_b_i  (t0_idx_u),
        .wr_en_i     (t0_we),
        .wr_idx_i    (t0_idx_u),
        .wr_data_i   (t0_wdata),
        .rd_data_a_o (t0_ent_f),
        .rd_data_b_o (t0_ent_u)
    );

    pred_table #(
        .DEPTH     (2**TAG_IDX_W),
        .entry_t   (tag_entry_t),
        .RESET_VAL (TAG_ENTRY_RST)
    ) u_t1 (
        .clk         (clk),
        .rst         (rst),
        .rd_idx_a_i  (t1_idx_f),
        .rd_idx_b_i  (t1_idx_u),
        .wr_en_i     (t1_we),
        .wr_idx_i    (t1_idx_u),
        .wr_data_i   (t1_wdata),
        .rd_data_a_o (t1_ent_f),
        .rd_data_b_o (t1_ent_u)
    );

endmodule

//--- inst_decode.sv
`timescale 1ns/1ps

module inst_decode import bpu_isa_pkg::*; (
    input  addr_t if_pc_i,
    input  inst_t if_inst_i,
    output logic  is_branch_o,
    output logic  is_jal_o,
    output logic  is_jalr_o,
    output addr_t jal_target_o,
    output addr_t branch_target_o
);

    opcode_t opc;
    addr_t   off_j;
    addr_t   off_b;

    assign opc = opcode_of(if_inst_i);

    // class from major opcode only, funct3 not checked
    assign is_branch_o = (opc == OPC_BRANCH);
    assign is_jal_o    = (opc == OPC_JAL);
    assign is_jalr_o   = (opc == OPC_JALR);

    assign off_j = imm_j(if_inst_i);
    assign off_b = imm_b(if_inst_i);

    // pc-relative targets, formed for every word
    assign jal_target_o    = if_pc_i + off_j;
    assign branch_target_o = if_pc_i + off_b;

endmodule

//--- pred_table.sv
`timescale 1ns/1ps

module pred_table #(
    parameter int     DEPTH     = 256,
    parameter type    entry_t   = logic [1:0],
    parameter entry_t RESET_VAL = '0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [$clog2(DEPTH)-1:0] rd_idx_a_i,
    input  logic [$clog2(DEPTH)-1:0] rd_idx_b_i,
    input  logic                     wr_en_i,
    input  logic [$clog2(DEPTH)-1:0] wr_idx_i,
    input  entry_t                   wr_data_i,
    output entry_t                   rd_data_a_o,
    output entry_t                   rd_data_b_o
);

    entry_t mem [DEPTH];

    // whole array returns to its initial state on reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= RESET_VAL;
            end
        end else if (wr_en_i) begin
            mem[wr_idx_i] <= wr_data_i;
        end
    end

    // a: fetch lookup, b: update-time lookup
    assign rd_data_a_o = mem[rd_idx_a_i];
    assign rd_data_b_o = mem[rd_idx_b_i];

endmodule

//--- bpu_update_if.sv
`timescale 1ns/1ps

interface bpu_update_if
    import bpu_isa_pkg::*, bpu_cfg_pkg::*;
();

    logic  valid;         // one strobe per resolved transfer
    logic  taken;
    logic  pred_correct;  // fetch prediction matched the outcome
    addr_t pc;
    hist_t history;       // history the fetch lookup used
    addr_t target;

    modport source (
        output valid, taken, pred_correct, pc, history, target
    );

    modport sink (
        input valid, taken, pred_correct, pc, history, target
    );

endinterface

//--- bpu_cfg_pkg.sv
package bpu_cfg_pkg;
    import bpu_isa_pkg::*;

    localparam int HIST_W     = 16;
    localparam int BM_IDX_W   = 9;   // pc[9:1]
    localparam int TAG_IDX_W  = 8;
    localparam int TAG_W      = 10;
    localparam int PART_TAG_W = 6;   // upper tag bits compared at lookup
    localparam int BTB_IDX_W  = 8;   // pc[9:2]
    localparam int BTB_TAG_W  = 22;  // pc[31:10]

    typedef logic [HIST_W-1:0] hist_t;
    typedef logic [1:0]        ctr_t;
    typedef logic [TAG_W-1:0]  tag_t;

    localparam ctr_t CTR_STRONG_NT = 2'd0;
    localparam ctr_t CTR_WEAK_NT   = 2'd1;
    localparam ctr_t CTR_WEAK_T    = 2'd2;
    localparam ctr_t CTR_STRONG_T  = 2'd3;

    typedef struct packed {
        tag_t tag;
        ctr_t ctr;
    } tag_entry_t;

    typedef struct packed {
        logic                 valid;
        logic [BTB_TAG_W-1:0] tag;
        addr_t                target;
    } btb_entry_t;

    typedef enum logic [1:0] {
        BIMODAL,
        T0,
        T1
    } provider_e;

    localparam tag_entry_t TAG_ENTRY_RST = '{tag: '0, ctr: CTR_WEAK_NT};
    localparam btb_entry_t BTB_ENTRY_RST = '0;

    function automatic logic [BM_IDX_W-1:0] bm_index(addr_t pc);
        return pc[BM_IDX_W:1];
    endfunction

    // short history table folds the low history byte
    function automatic logic [TAG_IDX_W-1:0] t0_index(addr_t pc, hist_t h);
        return pc[TAG_IDX_W-1:0] ^ h[TAG_IDX_W-1:0];
    endfunction

    function automatic logic [TAG_IDX_W-1:0] t1_index(addr_t pc, hist_t h);
        return pc[TAG_IDX_W-1:0] ^ h[HIST_W-1 -: TAG_IDX_W];
    endfunction

    function automatic tag_t t0_tag(addr_t pc, hist_t h);
        return pc[TAG_IDX_W +: TAG_W] ^ h[HIST_W-1 -: TAG_W];
    endfunction

    function automatic tag_t t1_tag(addr_t pc, hist_t h);
        return pc[TAG_IDX_W +: TAG_W] ^ tag_t'(h[TAG_IDX_W-1:0]);
    endfunction

    function automatic logic part_match(tag_t stored, tag_t probe);
        return stored[TAG_W-1 -: PART_TAG_W] == probe[TAG_W-1 -: PART_TAG_W];
    endfunction

    // saturating step toward the outcome
    function automatic ctr_t ctr_step(ctr_t c, logic taken);
        if (taken) begin
            return (c == CTR_STRONG_T) ? c : c + 2'd1;
        end
        return (c == CTR_STRONG_NT) ? c : c - 2'd1;
    endfunction

endpackage

//--- bpu_isa_pkg.sv
package bpu_isa_pkg;

    localparam int XLEN  = 32;
    localparam int OPC_W = 7;

    typedef logic [XLEN-1:0]  addr_t;
    typedef logic [31:0]      inst_t;
    typedef logic [OPC_W-1:0] opcode_t;

    // control-transfer major opcodes
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;

    // opcode sits in the low bits of every format
    function automatic opcode_t opcode_of(inst_t inst);
        return inst[OPC_W-1:0];
    endfunction

    // B-type offset, sign from bit 31, bit 0 implied zero
    function automatic addr_t imm_b(inst_t inst);
        return {{(XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    endfunction

    // J-type offset
    function automatic addr_t imm_j(inst_t inst);
        return {{(XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

endpackage
